// ==== src/uartCfgPkg.sv ====
// UART configuration package
// Bit timing and frame format for a 10 MHz clock at 115200 baud
package uartCfgPkg;

  //////////////////////////////////////////////////
  // Bit timing
  //////////////////////////////////////////////////

  // 10 MHz / 115200 baud, rounded to 87 clocks per bit
  localparam int cClksPerBit = 87;
  // Clocks from the start-bit edge to its middle
  localparam int cHalfBit    = cClksPerBit / 2;
  // Counter width, must hold cClksPerBit - 1
  localparam int cCntWidth   = 7;

  //////////////////////////////////////////////////
  // Frame format, 8N1
  //////////////////////////////////////////////////
  localparam int cDataBits   = 8;
  // Width of the data bit index in Tx and Rx
  localparam int cBitIdxWidth = $clog2(cDataBits);

endpackage

// ==== src/uartTypesPkg.sv ====
// UART state types
// FSM encodings shared by the transmitter, receiver and assertions
package uartTypesPkg;

  //////////////////////////////////////////////////
  // Transmitter FSM
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    txIdle  = 3'd0,  // Line high, waiting for i_txDv
    txStart = 3'd1,  // Start bit on the line
    txData  = 3'd2,  // Data bits, LSB first
    txStop  = 3'd3,  // Stop bit on the line
    txDone  = 3'd4   // One cycle, done strobe
  } txState_t;

  //////////////////////////////////////////////////
  // Receiver FSM
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    rxIdle   = 3'd0,  // Waiting for a falling edge
    rxStart  = 3'd1,  // Waiting for mid start bit
    rxData   = 3'd2,  // Sampling data bits
    rxStop   = 3'd3,  // Waiting for mid stop bit
    rxReport = 3'd4   // One cycle, valid or framing error
  } rxState_t;

endpackage

// ==== src/uartBitTimer.sv ====
// UART bit timer
// Down-counter giving one tick per serial bit, first tick optionally at half a bit
module uartBitTimer
  import uartCfgPkg::*;
(
  input  logic r_Clock,
  input  logic i_rst,
  input  logic i_restart,
  input  logic i_half,
  output logic o_tick
);

  // Clocks left in the current bit, tick on zero
  logic [cCntWidth-1:0] bitCnt;

  always_ff @(posedge r_Clock)
  begin
    if (i_rst)
    begin
      bitCnt <= cCntWidth'(cClksPerBit - 1);
    end
    else if (i_restart)
    begin
      // Half mode lands the first tick in the middle of a bit
      if (i_half)
        bitCnt <= cCntWidth'(cHalfBit - 1);
      else
        bitCnt <= cCntWidth'(cClksPerBit - 1);
    end
    else if (bitCnt == '0)
    begin
      // Expired, every later bit is a full bit
      bitCnt <= cCntWidth'(cClksPerBit - 1);
    end
    else
    begin
      bitCnt <= bitCnt - 1'b1;
    end
  end

  // One-cycle tick on the last clock of the period
  assign o_tick = (bitCnt == '0);

endmodule

// ==== src/uartTx.sv ====
// UART transmitter
// Serializes one byte into an 8N1 frame, LSB first, with active and done flags
module uartTx
  import uartCfgPkg::*;
  import uartTypesPkg::*;
(
  input  logic       r_Clock,
  input  logic       i_rst,
  input  logic       i_txDv,
  input  logic [7:0] i_txByte,
  output logic       o_txSerial,
  output logic       o_txActive,
  output logic       o_txDone
);

  txState_t                 state;
  logic                     accept;
  logic                     bitTick;
  logic [cBitIdxWidth-1:0]  bitIdx;
  logic [cDataBits-1:0]     txShift;
  logic                     serialReg;

  // Strobe only counts while idle, otherwise dropped
  assign accept = (state == txIdle) && i_txDv;

  //////////////////////////////////////////////////
  // Bit timing
  //////////////////////////////////////////////////

  // Timer restarts on the accepting edge, start bit lasts a full bit
  uartBitTimer txTimer0 (
    .r_Clock   (r_Clock),
    .i_rst     (i_rst),
    .i_restart (accept),
    .i_half    (1'b0),
    .o_tick    (bitTick)
  );

  //////////////////////////////////////////////////
  // FSM and line driver
  //////////////////////////////////////////////////
  always_ff @(posedge r_Clock)
  begin
    if (i_rst)
    begin
      state     <= txIdle;
      serialReg <= 1'b1;
      bitIdx    <= '0;
    end
    else
    begin
      case (state)
        txIdle:
          if (accept)
          begin
            // Start bit goes out on the next cycle
            serialReg <= 1'b0;
            state     <= txStart;
          end
        txStart:
          if (bitTick)
          begin
            serialReg <= txShift[0];
            bitIdx    <= '0;
            state     <= txData;
          end
        txData:
          if (bitTick)
          begin
            if (bitIdx == cBitIdxWidth'(cDataBits - 1))
            begin
              // Last data bit done, stop bit high
              serialReg <= 1'b1;
              state     <= txStop;
            end
            else
            begin
              serialReg <= txShift[0];
              bitIdx    <= bitIdx + 1'b1;
            end
          end
        txStop:
          if (bitTick)
            state <= txDone;
        txDone:
          state <= txIdle;
        default:
          state <= txIdle;
      endcase
    end
  end

  // Shift register, bit 0 is always the next bit to send
  always_ff @(posedge r_Clock)
  begin
    if (accept)
      txShift <= i_txByte;
    else if (bitTick && (state == txStart || state == txData))
      txShift <= txShift >> 1;
  end

  assign o_txSerial = serialReg;
  // Active over start, data and stop bits
  assign o_txActive = (state == txStart) || (state == txData) || (state == txStop);
  // Done lands on the cycle the stop bit ends
  assign o_txDone   = (state == txDone);

endmodule

// ==== src/uartRx.sv ====
// UART receiver
// Finds the start edge, samples mid-bit and flags valid bytes or framing errors
module uartRx
  import uartCfgPkg::*;
  import uartTypesPkg::*;
(
  input  logic       r_Clock,
  input  logic       i_rst,
  input  logic       i_rxSerial,
  output logic       o_rxDv,
  output logic [7:0] o_rxByte,
  output logic       o_rxFrameErr
);

  rxState_t                 state;
  logic                     rxMeta;
  logic                     rxSync;
  logic                     rxPrev;
  logic                     fallEdge;
  logic                     startDet;
  logic                     bitTick;
  logic [cBitIdxWidth-1:0]  bitIdx;
  logic [cDataBits-1:0]     rxShift;
  logic                     stopOk;

  //////////////////////////////////////////////////
  // Input synchronizer and edge detect
  //////////////////////////////////////////////////

  // Line idles high, so the chain resets high
  always_ff @(posedge r_Clock)
  begin
    if (i_rst)
    begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
      rxPrev <= 1'b1;
    end
    else
    begin
      rxMeta <= i_rxSerial;
      rxSync <= rxMeta;
      rxPrev <= rxSync;
    end
  end

  assign fallEdge = rxPrev && !rxSync;
  // A held-low line after a bad frame does not retrigger
  assign startDet = (state == rxIdle) && fallEdge;

  // Half-bit restart puts every later tick at mid-bit
  uartBitTimer rxTimer0 (
    .r_Clock   (r_Clock),
    .i_rst     (i_rst),
    .i_restart (startDet),
    .i_half    (1'b1),
    .o_tick    (bitTick)
  );

  //////////////////////////////////////////////////
  // Receive FSM
  //////////////////////////////////////////////////
  always_ff @(posedge r_Clock)
  begin
    if (i_rst)
    begin
      state    <= rxIdle;
      bitIdx   <= '0;
      stopOk   <= 1'b0;
      o_rxByte <= '0;
    end
    else
    begin
      case (state)
        rxIdle:
          if (startDet)
            state <= rxStart;
        rxStart:
          if (bitTick)
          begin
            // Still low at mid-bit means a real start bit
            if (!rxSync)
            begin
              bitIdx <= '0;
              state  <= rxData;
            end
            else
              state <= rxIdle;
          end
        rxData:
          if (bitTick)
          begin
            if (bitIdx == cBitIdxWidth'(cDataBits - 1))
              state <= rxStop;
            else
              bitIdx <= bitIdx + 1'b1;
          end
        rxStop:
          if (bitTick)
          begin
            // Byte is published either way, the strobe tells which
            stopOk   <= rxSync;
            o_rxByte <= rxShift;
            state    <= rxReport;
          end
        rxReport:
          state <= rxIdle;
        default:
          state <= rxIdle;
      endcase
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge r_Clock)
  begin
    if (bitTick && state == rxData)
      rxShift <= {rxSync, rxShift[cDataBits-1:1]};
  end

  // Exactly one of the two strobes for one cycle per frame
  assign o_rxDv       = (state == rxReport) && stopOk;
  assign o_rxFrameErr = (state == rxReport) && !stopOk;

endmodule

// ==== src/uartLink.sv ====
// UART link top level
// One transmitter and one receiver, each with its own bit timer
module uartLink (
  input  logic       r_Clock,
  input  logic       i_rst,
  // Transmit side
  input  logic       i_txDv,
  input  logic [7:0] i_txByte,
  output logic       o_txSerial,
  output logic       o_txActive,
  output logic       o_txDone,
  // Receive side
  input  logic       i_rxSerial,
  output logic       o_rxDv,
  output logic [7:0] o_rxByte,
  output logic       o_rxFrameErr
);

  //////////////////////////////////////////////////
  // Transmitter
  //////////////////////////////////////////////////
  uartTx tx0 (
    .r_Clock    (r_Clock),
    .i_rst      (i_rst),
    .i_txDv     (i_txDv),
    .i_txByte   (i_txByte),
    .o_txSerial (o_txSerial),
    .o_txActive (o_txActive),
    .o_txDone   (o_txDone)
  );

  //////////////////////////////////////////////////
  // Receiver, independent of the transmitter
  //////////////////////////////////////////////////
  uartRx rx0 (
    .r_Clock      (r_Clock),
    .i_rst        (i_rst),
    .i_rxSerial   (i_rxSerial),
    .o_rxDv       (o_rxDv),
    .o_rxByte     (o_rxByte),
    .o_rxFrameErr (o_rxFrameErr)
  );

endmodule

// ==== testbench/uartTb_assert.sv ====
// UART link assertions
// Strobe and idle-line rules, bound to the link top level
module uartTb_assert (
  input logic r_Clock,
  input logic i_rst,
  input logic i_txSerial,
  input logic i_txActive,
  input logic i_txDone,
  input logic i_rxDv,
  input logic i_rxFrameErr
);
  timeunit 1ns;
  timeprecision 10ps;

  // Done strobe is one cycle wide
  txDonePulse: assert property (@(posedge r_Clock) disable iff (i_rst) i_txDone |=> !i_txDone)
    else $error("o_txDone high on consecutive cycles");

  // Same for the receive valid strobe
  rxDvPulse: assert property (@(posedge r_Clock) disable iff (i_rst) i_rxDv |=> !i_rxDv)
    else $error("o_rxDv high on consecutive cycles");

  // A frame is either valid or bad, never both
  rxOneResult: assert property (@(posedge r_Clock) disable iff (i_rst) !(i_rxDv && i_rxFrameErr))
    else $error("o_rxDv and o_rxFrameErr high together");

  // Idle line stays at the mark level
  txIdleHigh: assert property (@(posedge r_Clock) disable iff (i_rst) !i_txActive |-> i_txSerial)
    else $error("o_txSerial low while o_txActive is low");

endmodule

// ==== testbench/uartTb.sv ====
// UART link testbench
// Runs golden-file operations against the link and checks the line and the strobes
module uartTb
  import uartCfgPkg::*;
();
  timeunit 1ns;
  timeprecision 10ps;

  logic       r_Clock = 1'b0;
  logic       i_rst;
  logic       i_txDv;
  logic [7:0] i_txByte;
  logic       i_rxSerial;
  logic       o_txSerial;
  logic       o_txActive;
  logic       o_txDone;
  logic       o_rxDv;
  logic [7:0] o_rxByte;
  logic       o_rxFrameErr;
  // Receive line as driven by the testbench, and the loopback select
  logic       rxLine = 1'b1;
  logic       loopMode = 1'b0;
  logic       prevActive = 1'b0;
  logic       goldenLoaded = 1'b0;
  int         valueErrs = 0;
  int         otherErrs = 0;
  int         txDoneCnt = 0;
  int         rxDvCnt = 0;
  int         rxErrCnt = 0;
  // Golden operations, one entry per line of the file
  byte        opMode[$];
  logic [7:0] opByte[$];
  int         opStop[$];
  byte        opExp[$];

  // Loopback feeds the transmitter straight into the receiver
  assign i_rxSerial = loopMode ? o_txSerial : rxLine;

  uartLink dut0 (
    .r_Clock      (r_Clock),
    .i_rst        (i_rst),
    .i_txDv       (i_txDv),
    .i_txByte     (i_txByte),
    .o_txSerial   (o_txSerial),
    .o_txActive   (o_txActive),
    .o_txDone     (o_txDone),
    .i_rxSerial   (i_rxSerial),
    .o_rxDv       (o_rxDv),
    .o_rxByte     (o_rxByte),
    .o_rxFrameErr (o_rxFrameErr)
  );

  bind uartLink uartTb_assert assert0 (
    .r_Clock      (r_Clock),
    .i_rst        (i_rst),
    .i_txSerial   (o_txSerial),
    .i_txActive   (o_txActive),
    .i_txDone     (o_txDone),
    .i_rxDv       (o_rxDv),
    .i_rxFrameErr (o_rxFrameErr)
  );

  // 100 ns period
  always #50 r_Clock = ~r_Clock;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Inputs change 5 ns after the rising edge
  task automatic driveEdge();
    @(posedge r_Clock);
    #5;
  endtask

  task automatic reportMismatch(input string name, input int got, input int exp);
    $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    valueErrs++;
  endtask

  task automatic reportFailure(input string what);
    $display("At %0t ns: %s", $time, what);
    otherErrs++;
  endtask

  // One-cycle transmit strobe
  task automatic pulseTxDv(input logic [7:0] data);
    i_txDv   = 1'b1;
    i_txByte = data;
    driveEdge();
    i_txDv   = 1'b0;
  endtask

  // One 8N1 frame on the receive line, LSB first, 87 clocks per bit
  task automatic sendFrame(input logic [7:0] data, input logic stopLvl);
    logic [9:0] bits;
    bits = {stopLvl, data, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
      rxLine = bits[i];
      repeat (cClksPerBit) driveEdge();
    end
  endtask

  // Line monitor, finds the start edge then samples every bit in its middle
  task automatic decodeTxLine(output logic [7:0] data, output logic stopLvl, output bit found);
    int waitCnt;
    waitCnt = 0;
    data    = '0;
    stopLvl = 1'b0;
    while (o_txSerial && waitCnt < 4 * cClksPerBit)
    begin
      @(negedge r_Clock);
      waitCnt++;
    end
    found = !o_txSerial;
    if (found)
    begin
      repeat (cClksPerBit / 2) @(negedge r_Clock);
      for (int i = 0; i < 8; i++)
      begin
        repeat (cClksPerBit) @(negedge r_Clock);
        data[i] = o_txSerial;
      end
      repeat (cClksPerBit) @(negedge r_Clock);
      stopLvl = o_txSerial;
    end
  endtask

  // Polls a strobe count until it moves past base, limited to 12 bit times
  task automatic waitStrobe(input bit rxSide, input int base);
    int n;
    n = 0;
    while (((rxSide ? rxDvCnt + rxErrCnt : txDoneCnt) == base) && n < 12 * cClksPerBit)
    begin
      driveEdge();
      n++;
    end
    if (n == 12 * cClksPerBit)
    begin
      if (rxSide)
        reportFailure("timed out waiting for o_rxDv or o_rxFrameErr");
      else
        reportFailure("timed out waiting for o_txDone");
    end
  endtask

  // Golden file, lines starting with # are comments
  task automatic loadGolden();
    int         fd;
    int         stopLvl;
    string      line;
    byte        mode;
    byte        expRes;
    logic [7:0] data;
    fd = $fopen("testbench/uartGolden.txt", "r");
    if (fd == 0)
      reportFailure("could not open testbench/uartGolden.txt");
    else
    begin
      while (!$feof(fd))
      begin
        if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#")
        begin
          if ($sscanf(line, "%c %h %d %c", mode, data, stopLvl, expRes) == 4)
          begin
            opMode.push_back(mode);
            opByte.push_back(data);
            opStop.push_back(stopLvl);
            opExp.push_back(expRes);
          end
          else
            reportFailure({"unreadable golden line: ", line});
        end
      end
      $fclose(fd);
    end
    goldenLoaded = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Strobe counters and done alignment
  //////////////////////////////////////////////////
  always @(negedge r_Clock)
  begin
    if (!i_rst)
    begin
      if (o_txDone)
        txDoneCnt++;
      if (o_rxDv)
        rxDvCnt++;
      if (o_rxFrameErr)
        rxErrCnt++;
      // Done marks the same cycle active drops
      if (o_txDone && (o_txActive || !prevActive))
        reportFailure("o_txDone does not line up with o_txActive falling");
      if (!o_txActive && prevActive && !o_txDone)
        reportFailure("o_txActive fell without o_txDone");
    end
    prevActive = o_txActive;
  end

  // Watchdog, 12 bit times per golden operation plus two spare
  initial
  begin
    wait (goldenLoaded);
    #((opMode.size() + 2) * 12 * cClksPerBit * 100);
    $display("Watchdog expired before the golden operations finished");
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    logic [7:0] gotByte;
    logic       gotStop;
    bit         found;
    int         doneBase;
    int         dvBase;
    int         errBase;
    int         expDv;
    i_rst    = 1'b1;
    i_txDv   = 1'b0;
    i_txByte = 8'h00;
    void'($urandom(32'h9d7));
    loadGolden();
    if (opMode.size() == 0)
      reportFailure("golden file holds no operations");
    repeat (3) @(posedge r_Clock);
    #5;
    i_rst = 1'b0;

    // Reset state before any traffic
    if (o_txSerial !== 1'b1)
      reportMismatch("o_txSerial", int'(o_txSerial), 1);
    if (o_txActive !== 1'b0)
      reportMismatch("o_txActive", int'(o_txActive), 0);
    if (o_txDone !== 1'b0)
      reportMismatch("o_txDone", int'(o_txDone), 0);
    if (o_rxDv !== 1'b0)
      reportMismatch("o_rxDv", int'(o_rxDv), 0);
    if (o_rxFrameErr !== 1'b0)
      reportMismatch("o_rxFrameErr", int'(o_rxFrameErr), 0);
    if (o_rxByte !== 8'h00)
      reportMismatch("o_rxByte", int'(o_rxByte), 0);

    for (int k = 0; k < opMode.size(); k++)
    begin
      // Random idle gap of 1 to 40 clocks
      repeat ($urandom % 40 + 1) driveEdge();
      doneBase = txDoneCnt;
      dvBase   = rxDvCnt;
      errBase  = rxErrCnt;
      case (opMode[k])
        "T":
        begin
          fork
            pulseTxDv(opByte[k]);
            decodeTxLine(gotByte, gotStop, found);
          join
          waitStrobe(1'b0, doneBase);
          driveEdge();
          if (!found)
            reportFailure("no start bit seen on o_txSerial");
          if (gotByte !== opByte[k])
            reportMismatch("o_txSerial data", int'(gotByte), int'(opByte[k]));
          if (gotStop !== opStop[k][0])
            reportMismatch("o_txSerial stop bit", int'(gotStop), opStop[k]);
          if (txDoneCnt - doneBase != 1)
            reportMismatch("o_txDone count", txDoneCnt - doneBase, 1);
        end
        "R":
        begin
          sendFrame(opByte[k], opStop[k][0]);
          waitStrobe(1'b1, dvBase + errBase);
          // Back to mark for one bit after a bad stop bit
          rxLine = 1'b1;
          if (opStop[k] == 0)
            repeat (cClksPerBit) driveEdge();
        end
        "L":
        begin
          loopMode = 1'b1;
          pulseTxDv(opByte[k]);
          repeat (2 * cClksPerBit) driveEdge();
          if (o_txActive !== 1'b1)
            reportFailure("o_txActive low in the middle of a frame");
          // Mid-frame strobe, must be dropped
          pulseTxDv(~opByte[k]);
          waitStrobe(1'b0, doneBase);
          repeat (cClksPerBit) driveEdge();
          if (o_txActive !== 1'b0)
            reportFailure("strobe sent while busy started a second frame");
          if (txDoneCnt - doneBase != 1)
            reportMismatch("o_txDone count", txDoneCnt - doneBase, 1);
          loopMode = 1'b0;
        end
        default:
          reportFailure("unknown mode in golden file");
      endcase

      // Receiver result for R and L operations
      if (opMode[k] == "R" || opMode[k] == "L")
      begin
        expDv = (opExp[k] == "V") ? 1 : 0;
        if (rxDvCnt - dvBase != expDv)
          reportMismatch("o_rxDv count", rxDvCnt - dvBase, expDv);
        if (rxErrCnt - errBase != 1 - expDv)
          reportMismatch("o_rxFrameErr count", rxErrCnt - errBase, 1 - expDv);
        if (o_rxByte !== opByte[k])
          reportMismatch("o_rxByte", int'(o_rxByte), int'(opByte[k]));
      end
    end

    $display("Errors: %0d value mismatches, %0d other failures, %0d total",
             valueErrs, otherErrs, valueErrs + otherErrs);
    if (valueErrs + otherErrs == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== src.f ====
src/uartCfgPkg.sv
src/uartTypesPkg.sv
src/uartBitTimer.sv
src/uartTx.sv
src/uartRx.sv
src/uartLink.sv
testbench/uartTb_assert.sv
testbench/uartTb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = uartTb
FILELIST   = src.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Test passed
COMMON     = --timing --timescale 1ns/10ps --assert
LINT_FLAGS = --lint-only $(COMMON)
SIM_FLAGS  = --binary $(COMMON) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/uartGolden.txt ====
# mode byte stop expect, mode is T transmit, R receive or L loopback
# byte in hex, stop is the stop-bit level, expect is V valid or F framing error
T 55 1 V
T a3 1 V
T 00 1 V
T ff 1 V
R 3c 1 V
R 81 1 V
R 7e 0 F
R 00 1 V
R c5 0 F
L 5a 1 V
L 01 1 V
T 80 1 V
R ff 1 V
R 10 0 F
L e7 1 V
L 96 1 V
T 6b 1 V
R 2d 1 V
